//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= -j 0

SOURCES := $(wildcard hw/*.sv dv/*.sv include/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- include/rv_tb_ref.svh
`ifndef RV_TB_REF_SVH
`define RV_TB_REF_SVH

typedef rv_pkg::word_t prog_q_t[$];

typedef struct packed {
  rv_pkg::word_t    addr;
  rv_pkg::byte_en_t mask;
  rv_pkg::word_t    data;
} ref_store_t;

function automatic rv_pkg::word_t enc_r(logic [6:0] f7, rv_pkg::reg_addr_t rs2, rs1,
                                        logic [2:0] f3, rv_pkg::reg_addr_t rd);
  return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
endfunction

function automatic rv_pkg::word_t enc_i(logic [11:0] imm, rv_pkg::reg_addr_t rs1,
                                        logic [2:0] f3, rv_pkg::reg_addr_t rd,
                                        logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic rv_pkg::word_t enc_s(logic [11:0] imm, rv_pkg::reg_addr_t rs2, rs1,
                                        logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OPC_STORE};
endfunction

function automatic rv_pkg::word_t enc_b(logic [12:0] imm, rv_pkg::reg_addr_t rs2, rs1,
                                        logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
endfunction

// Only value[31:12] is encoded
function automatic rv_pkg::word_t enc_u(rv_pkg::word_t value, rv_pkg::reg_addr_t rd,
                                        logic [6:0] op);
  return {value[31:12], rd, op};
endfunction

function automatic rv_pkg::word_t enc_j(logic [20:0] imm, rv_pkg::reg_addr_t rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
endfunction

// LUI rounds up when ADDI will sign-extend a negative low part
function automatic void prog_li(ref prog_q_t p, input rv_pkg::reg_addr_t rd,
                                input rv_pkg::word_t value);
  p.push_back(enc_u(value + 32'h800, rd, rv_pkg::OPC_LUI));
  p.push_back(enc_i(value[11:0], rd, 3'd0, rd, rv_pkg::OPC_OPIMM));
endfunction

// Halt is a word store of x0 to 0xFFC, then a jump to itself
function automatic void prog_halt(ref prog_q_t p);
  p.push_back(enc_u(32'h1000, 5'd31, rv_pkg::OPC_LUI));
  p.push_back(enc_s(12'hffc, 5'd0, 5'd31, 3'd2));
  p.push_back(enc_j(21'd0, 5'd0));
endfunction

function automatic rv_pkg::word_t ref_alu(logic [2:0] f3, logic alt,
                                          rv_pkg::word_t a, rv_pkg::word_t b);
  case (f3)
    3'd0:    return alt ? a - b : a + b;
    3'd1:    return a << b[4:0];
    3'd2:    return {31'b0, $signed(a) < $signed(b)};
    3'd3:    return {31'b0, a < b};
    3'd4:    return a ^ b;
    3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6:    return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic ref_br(logic [2:0] f3, rv_pkg::word_t a, rv_pkg::word_t b);
  case (f3)
    3'd0:    return a == b;
    3'd1:    return a != b;
    3'd4:    return $signed(a) < $signed(b);
    3'd5:    return $signed(a) >= $signed(b);
    3'd6:    return a < b;
    3'd7:    return a >= b;
    default: return 1'b0;
  endcase
endfunction

// Runs from RESET_PC on zeroed registers and a zeroed 4 KiB data memory
function automatic void rv_ref_run(input prog_q_t prog, ref ref_store_t st[$]);
  rv_pkg::word_t    x [32];
  logic [7:0]       mem [4096];
  rv_pkg::word_t    pc;
  rv_pkg::word_t    ins;
  rv_pkg::word_t    a;
  rv_pkg::word_t    b;
  rv_pkg::word_t    iimm;
  rv_pkg::word_t    simm;
  rv_pkg::word_t    ea;
  rv_pkg::word_t    w;
  rv_pkg::word_t    r;
  rv_pkg::word_t    nx;
  rv_pkg::byte_en_t m;
  logic [2:0]       f3;
  logic             wr;
  x = '{default: '0};
  mem = '{default: '0};
  pc = rv_pkg::RESET_PC;
  st.delete();
  for (int step = 0; step < 20000; step++) begin
    ins = (pc[31:2] < prog.size()) ? prog[pc[31:2]] : '0;
    a = x[ins[19:15]];
    b = x[ins[24:20]];
    f3 = ins[14:12];
    iimm = {{20{ins[31]}}, ins[31:20]};
    simm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    nx = pc + 32'd4;
    r = '0;
    wr = 1'b1;
    case (ins[6:0])
      rv_pkg::OPC_LUI:   r = {ins[31:12], 12'b0};
      rv_pkg::OPC_AUIPC: r = pc + {ins[31:12], 12'b0};
      rv_pkg::OPC_JAL: begin
        r = nx;
        nx = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      rv_pkg::OPC_JALR: begin
        r = nx;
        nx = (a + iimm) & ~32'd1;
      end
      rv_pkg::OPC_BRANCH: begin
        wr = 1'b0;
        if (ref_br(f3, a, b))
          nx = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      rv_pkg::OPC_LOAD: begin
        ea = a + iimm;
        w = {mem[{ea[11:2], 2'd3}], mem[{ea[11:2], 2'd2}],
             mem[{ea[11:2], 2'd1}], mem[{ea[11:2], 2'd0}]};
        w = w >> {ea[1:0], 3'b000};
        case (f3)
          3'd0:    r = {{24{w[7]}}, w[7:0]};
          3'd1:    r = {{16{w[15]}}, w[15:0]};
          3'd4:    r = {24'b0, w[7:0]};
          3'd5:    r = {16'b0, w[15:0]};
          default: r = w;
        endcase
      end
      rv_pkg::OPC_STORE: begin
        wr = 1'b0;
        ea = a + simm;
        m = (f3 == 3'd0) ? 4'b0001 : (f3 == 3'd1) ? 4'b0011 : 4'b1111;
        m = m << ea[1:0];
        w = (f3 == 3'd0) ? {4{b[7:0]}} : (f3 == 3'd1) ? {2{b[15:0]}} : b;
        for (int i = 0; i < 4; i++) begin
          if (m[i])
            mem[{ea[11:2], i[1:0]}] = w[8*i +: 8];
        end
        st.push_back('{addr: {ea[31:2], 2'b00}, mask: m, data: w});
        if ({ea[31:2], 2'b00} == 32'hffc)
          return;
      end
      rv_pkg::OPC_OPIMM: r = ref_alu(f3, (f3 == 3'd5) & ins[30], a, iimm);
      rv_pkg::OPC_OP:    r = ref_alu(f3, ins[30], a, b);
      default:           wr = 1'b0;
    endcase
    if (wr && ins[11:7] != 5'd0)
      x[ins[11:7]] = r;
    pc = nx;
  end
endfunction

`endif

//--- dv/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

  `include "rv_tb_ref.svh"

  logic             clk;
  logic             reset;
  rv_pkg::word_t    instr_addr;
  rv_pkg::word_t    instr_in;
  rv_pkg::word_t    data_addr;
  rv_pkg::byte_en_t data_wr;
  rv_pkg::word_t    data_in;
  logic [7:0]       data_out0;
  logic [7:0]       data_out1;
  logic [7:0]       data_out2;
  logic [7:0]       data_out3;
  rv_pkg::word_t    store_lanes;

  rv_pkg::word_t imem [4096];
  rv_pkg::word_t dmem [1024];
  ref_store_t    exp_stores [$];
  prog_q_t       prog;
  string         test_name;
  logic          halted;
  int            store_slot;

  rv_core rv_core_i (
    .clk        (clk),
    .reset      (reset),
    .instr_addr (instr_addr),
    .instr_in   (instr_in),
    .data_addr  (data_addr),
    .data_wr    (data_wr),
    .data_in    (data_in),
    .data_out0  (data_out0),
    .data_out1  (data_out1),
    .data_out2  (data_out2),
    .data_out3  (data_out3)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  assign instr_in    = imem[instr_addr[13:2]];
  assign data_in     = dmem[data_addr[11:2]];
  assign store_lanes = {data_out3, data_out2, data_out1, data_out0};

  // Data memory is cleared while reset is held
  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 1024; i++) begin
        dmem[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (data_wr[i]) begin
          dmem[data_addr[11:2]][8*i +: 8] <= store_lanes[8*i +: 8];
        end
      end
    end
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "%s", msg);
  endtask

  task automatic report_mismatch(input string what, input rv_pkg::word_t expected,
                                 input rv_pkg::word_t actual);
    $display("FAILED %s: %s expected %h actual %h", test_name, what, expected, actual);
    $display("Verification failed");
    $fatal(1, "%s mismatch", what);
  endtask

  task automatic check_store();
    ref_store_t e;
    assert (exp_stores.size() > 0)
      else fail_run($sformatf("Store to %h in test %s was not expected", data_addr, test_name));
    e = exp_stores.pop_front();
    assert (data_addr == e.addr) else report_mismatch("store address", e.addr, data_addr);
    assert (data_wr == e.mask) else report_mismatch("store mask", 32'(e.mask), 32'(data_wr));
    assert (store_lanes == e.data) else report_mismatch("store data", e.data, store_lanes);
    if (e.addr == 32'hffc) begin
      halted = 1'b1;
    end
  endtask

  always @(posedge clk) begin
    if (!reset && data_wr != '0) begin
      check_store();
    end
  end

  task automatic check_reset_outputs();
    assert (instr_addr == rv_pkg::RESET_PC)
      else report_mismatch("reset instr_addr", rv_pkg::RESET_PC, instr_addr);
    assert (data_wr == '0) else report_mismatch("reset data_wr", 32'h0, 32'(data_wr));
  endtask

  // Each store goes to the next word of a 1 KiB result area at x10
  function automatic void emit_store(ref prog_q_t p, input rv_pkg::reg_addr_t rs);
    p.push_back(enc_s(12'((store_slot * 4) % 1024), rs, 5'd10, 3'd2));
    store_slot++;
  endfunction

  function automatic void build_alu_prog(ref prog_q_t p);
    rv_pkg::word_t vals [6] = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff,
                                32'h0000_0001, 32'h0000_0000, 32'h0000_001f};
    logic [11:0]   imms [4] = '{12'h800, 12'h7ff, 12'hfff, 12'h000};
    logic [4:0]    shamts [3] = '{5'd0, 5'd31, 5'd1};
    logic [2:0]    imm_f3 [6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
    logic [2:0]    f3;
    logic          alt;
    p.delete();
    store_slot = 0;
    prog_li(p, 5'd10, 32'h100);
    for (int i = 0; i < 6; i++) begin
      prog_li(p, rv_pkg::reg_addr_t'(i + 1), vals[i]);
    end
    for (int a = 1; a <= 6; a++) begin
      for (int b = 1; b <= 6; b++) begin
        for (int op = 0; op < 10; op++) begin
          alt = (op >= 8);
          if (op < 8) begin
            f3 = 3'(op);
          end else begin
            f3 = (op == 8) ? 3'd0 : 3'd5;
          end
          p.push_back(enc_r(alt ? 7'h20 : 7'h00, rv_pkg::reg_addr_t'(b),
                            rv_pkg::reg_addr_t'(a), f3, 5'd7));
          emit_store(p, 5'd7);
        end
      end
      for (int k = 0; k < 6; k++) begin
        for (int j = 0; j < 4; j++) begin
          p.push_back(enc_i(imms[j], rv_pkg::reg_addr_t'(a), imm_f3[k], 5'd7,
                            rv_pkg::OPC_OPIMM));
          emit_store(p, 5'd7);
        end
      end
      for (int s = 0; s < 3; s++) begin
        p.push_back(enc_i({7'h00, shamts[s]}, rv_pkg::reg_addr_t'(a), 3'd1, 5'd7,
                          rv_pkg::OPC_OPIMM));
        emit_store(p, 5'd7);
        p.push_back(enc_i({7'h00, shamts[s]}, rv_pkg::reg_addr_t'(a), 3'd5, 5'd7,
                          rv_pkg::OPC_OPIMM));
        emit_store(p, 5'd7);
        p.push_back(enc_i({7'h20, shamts[s]}, rv_pkg::reg_addr_t'(a), 3'd5, 5'd7,
                          rv_pkg::OPC_OPIMM));
        emit_store(p, 5'd7);
      end
    end
    prog_halt(p);
  endfunction

  // Byte and half stores at every offset, then loads of bytes with the top bit set
  function automatic void build_lsu_prog(ref prog_q_t p);
    logic [2:0] ld_f3 [5] = '{3'd0, 3'd4, 3'd1, 3'd5, 3'd2};
    int         step;
    p.delete();
    store_slot = 0;
    prog_li(p, 5'd10, 32'h100);
    prog_li(p, 5'd11, 32'h800);
    prog_li(p, 5'd1, 32'hf1e2_d3c4);
    prog_li(p, 5'd2, 32'h80ff_7f81);
    for (int off = 0; off < 4; off++) begin
      p.push_back(enc_s(12'(off), 5'd1, 5'd11, 3'd0));
    end
    p.push_back(enc_s(12'd4, 5'd1, 5'd11, 3'd1));
    p.push_back(enc_s(12'd6, 5'd1, 5'd11, 3'd1));
    p.push_back(enc_s(12'd8, 5'd1, 5'd11, 3'd2));
    p.push_back(enc_s(12'd16, 5'd2, 5'd11, 3'd2));
    for (int base = 0; base <= 16; base += 16) begin
      for (int k = 0; k < 5; k++) begin
        step = 1 << ld_f3[k][1:0];
        for (int off = 0; off < 4; off += step) begin
          p.push_back(enc_i(12'(base + off), 5'd11, ld_f3[k], 5'd7, rv_pkg::OPC_LOAD));
          emit_store(p, 5'd7);
        end
      end
    end
    prog_halt(p);
  endfunction

  function automatic void build_ctrl_prog(ref prog_q_t p);
    logic [2:0]        br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    rv_pkg::reg_addr_t pa [3] = '{5'd1, 5'd2, 5'd2};
    rv_pkg::reg_addr_t pb [3] = '{5'd2, 5'd1, 5'd3};
    p.delete();
    store_slot = 0;
    prog_li(p, 5'd10, 32'h100);
    prog_li(p, 5'd1, 32'hffff_ffff);
    prog_li(p, 5'd2, 32'h1);
    prog_li(p, 5'd3, 32'h1);
    // A taken branch skips the first marker and its store
    for (int k = 0; k < 6; k++) begin
      for (int j = 0; j < 3; j++) begin
        p.push_back(enc_b(13'd12, pb[j], pa[j], br_f3[k]));
        p.push_back(enc_i(12'd1, 5'd0, 3'd0, 5'd7, rv_pkg::OPC_OPIMM));
        emit_store(p, 5'd7);
        p.push_back(enc_i(12'd2, 5'd0, 3'd0, 5'd7, rv_pkg::OPC_OPIMM));
        emit_store(p, 5'd7);
      end
    end
    p.push_back(enc_j(21'd8, 5'd5));
    emit_store(p, 5'd0);
    emit_store(p, 5'd5);
    // Odd offset checks that JALR clears bit 0 of the target
    p.push_back(enc_u(32'h0, 5'd6, rv_pkg::OPC_AUIPC));
    p.push_back(enc_i(12'd17, 5'd6, 3'd0, 5'd7, rv_pkg::OPC_JALR));
    emit_store(p, 5'd0);
    emit_store(p, 5'd0);
    emit_store(p, 5'd7);
    emit_store(p, 5'd6);
    p.push_back(enc_u(32'habcd_e000, 5'd8, rv_pkg::OPC_LUI));
    emit_store(p, 5'd8);
    p.push_back(enc_u(32'h1234_5000, 5'd9, rv_pkg::OPC_AUIPC));
    emit_store(p, 5'd9);
    prog_halt(p);
  endfunction

  // x8 holds the data window base and is never a destination
  function automatic void build_random_prog(ref prog_q_t p);
    logic [2:0]        br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [2:0]        ld_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    int unsigned       kind;
    int unsigned       off;
    rv_pkg::reg_addr_t rd;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    logic [2:0]        f3;
    logic              alt;
    logic [4:0]        shamt;
    p.delete();
    prog_li(p, 5'd8, 32'h200);
    for (int r = 1; r < 8; r++) begin
      prog_li(p, rv_pkg::reg_addr_t'(r), $urandom());
    end
    for (int i = 0; i < 300; i++) begin
      kind  = $urandom_range(0, 9);
      rd    = rv_pkg::reg_addr_t'($urandom_range(1, 7));
      rs1   = rv_pkg::reg_addr_t'($urandom_range(0, 8));
      rs2   = rv_pkg::reg_addr_t'($urandom_range(0, 8));
      f3    = 3'($urandom_range(0, 7));
      alt   = 1'($urandom_range(0, 1));
      shamt = 5'($urandom_range(0, 31));
      off   = $urandom_range(0, 1023);
      if (kind <= 2 || (kind == 9 && i >= 296)) begin
        p.push_back(enc_r((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                          rs2, rs1, f3, rd));
      end else if (kind <= 4) begin
        if (f3 == 3'd1) begin
          p.push_back(enc_i({7'h00, shamt}, rs1, f3, rd, rv_pkg::OPC_OPIMM));
        end else if (f3 == 3'd5) begin
          p.push_back(enc_i({alt ? 7'h20 : 7'h00, shamt}, rs1, f3, rd, rv_pkg::OPC_OPIMM));
        end else begin
          p.push_back(enc_i(12'($urandom()), rs1, f3, rd, rv_pkg::OPC_OPIMM));
        end
      end else if (kind <= 6) begin
        f3  = ld_f3[$urandom_range(0, 4)];
        off = off - (off % (1 << f3[1:0]));
        p.push_back(enc_i(12'(off), 5'd8, f3, rd, rv_pkg::OPC_LOAD));
      end else if (kind <= 8) begin
        f3  = 3'($urandom_range(0, 2));
        off = off - (off % (1 << f3[1:0]));
        p.push_back(enc_s(12'(off), rs2, 5'd8, f3));
      end else begin
        f3 = br_f3[$urandom_range(0, 5)];
        p.push_back(enc_b(13'($urandom_range(1, 4) * 4), rs2, rs1, f3));
      end
    end
    prog_halt(p);
  endfunction

  task automatic run_program(input string name, input prog_q_t p);
    int cycles;
    test_name = name;
    rv_ref_run(p, exp_stores);
    @(negedge clk);
    reset  = 1'b1;
    halted = 1'b0;
    for (int i = 0; i < 4096; i++) begin
      imem[i] = (i < p.size()) ? p[i] : '0;
    end
    for (int c = 0; c < 4; c++) begin
      @(negedge clk);
      check_reset_outputs();
    end
    reset = 1'b0;
    check_reset_outputs();
    cycles = 0;
    while (!halted && cycles < 20000) begin
      @(negedge clk);
      cycles++;
    end
    assert (halted) else fail_run($sformatf("Program %s never halted", name));
    assert (exp_stores.size() == 0)
      else fail_run($sformatf("Program %s halted with %0d expected stores missing",
                              name, exp_stores.size()));
  endtask

  initial begin
    void'($urandom(10));
    reset  = 1'b1;
    halted = 1'b0;
    for (int i = 0; i < 4096; i++) begin
      imem[i] = '0;
    end
    build_alu_prog(prog);
    run_program("alu", prog);
    build_lsu_prog(prog);
    run_program("load_store", prog);
    build_ctrl_prog(prog);
    run_program("control", prog);
    build_random_prog(prog);
    run_program("random", prog);
    $display("Verification passed");
    $finish;
  end

endmodule

//--- flist.f
+incdir+include
hw/rv_pkg.sv
hw/rv_regfile.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_lsu.sv
hw/rv_core.sv
dv/rv_core_tb.sv

//--- hw/rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic             clk,
  input  logic             reset,
  output rv_pkg::word_t    instr_addr,
  input  rv_pkg::word_t    instr_in,
  output rv_pkg::word_t    data_addr,
  output rv_pkg::byte_en_t data_wr,
  input  rv_pkg::word_t    data_in,
  output logic [7:0]       data_out0,
  output logic [7:0]       data_out1,
  output logic [7:0]       data_out2,
  output logic [7:0]       data_out3
);

  rv_pkg::word_t instr;
  rv_pkg::word_t pc;
  logic          valid;
  rv_pkg::ctrl_t ctrl;
  rv_pkg::word_t rs1_data;
  rv_pkg::word_t rs2_data;
  rv_pkg::word_t alu_result;
  logic          taken;
  rv_pkg::word_t target;
  rv_pkg::word_t wb_data;

  rv_regfile rv_regfile_i (
    .clk      (clk),
    .reset    (reset),
    .wr       (ctrl.reg_wr),
    .rs1_addr (instr[19:15]),
    .rs2_addr (instr[24:20]),
    .rd_addr  (instr[11:7]),
    .wd       (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_fetch rv_fetch_i (
    .clk        (clk),
    .reset      (reset),
    .taken      (taken),
    .target     (target),
    .instr_addr (instr_addr),
    .instr_in   (instr_in),
    .instr      (instr),
    .pc         (pc),
    .valid      (valid)
  );

  rv_decode rv_decode_i (
    .instr (instr),
    .valid (valid),
    .ctrl  (ctrl)
  );

  rv_execute rv_execute_i (
    .ctrl       (ctrl),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .pc         (pc),
    .alu_result (alu_result),
    .taken      (taken),
    .target     (target)
  );

  rv_lsu rv_lsu_i (
    .ctrl       (ctrl),
    .alu_result (alu_result),
    .rs2_data   (rs2_data),
    .pc         (pc),
    .data_in    (data_in),
    .data_addr  (data_addr),
    .data_wr    (data_wr),
    .data_out0  (data_out0),
    .data_out1  (data_out1),
    .data_out2  (data_out2),
    .data_out3  (data_out3),
    .wb_data    (wb_data)
  );

endmodule

//--- hw/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
  input  rv_pkg::word_t instr,
  input  logic          valid,
  output rv_pkg::ctrl_t ctrl
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic            alt;
  rv_pkg::alu_op_t alu_fn;
  rv_pkg::word_t   imm_i;
  rv_pkg::word_t   imm_s;
  rv_pkg::word_t   imm_b;
  rv_pkg::word_t   imm_u;
  rv_pkg::word_t   imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  // funct7 bit 5 selects SUB and SRA
  assign alt    = instr[30];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    case (funct3)
      3'd0:    alu_fn = (opcode == rv_pkg::OPC_OP && alt) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'd1:    alu_fn = rv_pkg::ALU_SLL;
      3'd2:    alu_fn = rv_pkg::ALU_SLT;
      3'd3:    alu_fn = rv_pkg::ALU_SLTU;
      3'd4:    alu_fn = rv_pkg::ALU_XOR;
      3'd5:    alu_fn = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'd6:    alu_fn = rv_pkg::ALU_OR;
      default: alu_fn = rv_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    ctrl = '0;
    case (opcode)
      rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: begin
        ctrl.reg_wr = 1'b1;
        ctrl.src_a  = (opcode == rv_pkg::OPC_LUI) ? rv_pkg::SRC_A_ZERO : rv_pkg::SRC_A_PC;
        ctrl.src_b  = rv_pkg::SRC_B_IMM;
        ctrl.alu_op = rv_pkg::ALU_ADD;
        ctrl.imm    = imm_u;
      end
      rv_pkg::OPC_JAL, rv_pkg::OPC_JALR: begin
        ctrl.reg_wr = 1'b1;
        ctrl.wb_sel = rv_pkg::WB_LINK;
        ctrl.src_b  = rv_pkg::SRC_B_IMM;
        ctrl.alu_op = rv_pkg::ALU_PASS_B;
        ctrl.jal    = (opcode == rv_pkg::OPC_JAL);
        ctrl.jalr   = (opcode == rv_pkg::OPC_JALR);
        ctrl.imm    = (opcode == rv_pkg::OPC_JAL) ? imm_j : imm_i;
      end
      rv_pkg::OPC_BRANCH: begin
        ctrl.imm = imm_b;
        case (funct3)
          3'd0:    ctrl.branch = rv_pkg::BR_EQ;
          3'd1:    ctrl.branch = rv_pkg::BR_NE;
          3'd4:    ctrl.branch = rv_pkg::BR_LT;
          3'd5:    ctrl.branch = rv_pkg::BR_GE;
          3'd6:    ctrl.branch = rv_pkg::BR_LTU;
          3'd7:    ctrl.branch = rv_pkg::BR_GEU;
          default: ctrl.branch = rv_pkg::BR_NONE;
        endcase
      end
      rv_pkg::OPC_LOAD: begin
        ctrl.reg_wr        = 1'b1;
        ctrl.wb_sel        = rv_pkg::WB_LOAD;
        ctrl.mem_rd        = 1'b1;
        ctrl.mem_size      = funct3[1:0];
        ctrl.load_unsigned = funct3[2];
        ctrl.src_b         = rv_pkg::SRC_B_IMM;
        ctrl.alu_op        = rv_pkg::ALU_ADD;
        ctrl.imm           = imm_i;
      end
      rv_pkg::OPC_STORE: begin
        ctrl.mem_wr   = 1'b1;
        ctrl.mem_size = funct3[1:0];
        ctrl.src_b    = rv_pkg::SRC_B_IMM;
        ctrl.alu_op   = rv_pkg::ALU_ADD;
        ctrl.imm      = imm_s;
      end
      rv_pkg::OPC_OPIMM: begin
        ctrl.reg_wr = 1'b1;
        ctrl.src_b  = rv_pkg::SRC_B_IMM;
        ctrl.alu_op = alu_fn;
        ctrl.imm    = imm_i;
      end
      rv_pkg::OPC_OP: begin
        ctrl.reg_wr = 1'b1;
        ctrl.src_b  = rv_pkg::SRC_B_RS2;
        ctrl.alu_op = alu_fn;
      end
      default: ctrl = '0;
    endcase
    // Squashed and reset slots must not write or store
    if (!valid) begin
      ctrl = '0;
    end
  end

endmodule

//--- hw/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
  input  rv_pkg::ctrl_t ctrl,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  input  rv_pkg::word_t pc,
  output rv_pkg::word_t alu_result,
  output logic          taken,
  output rv_pkg::word_t target
);

  rv_pkg::word_t op_a;
  rv_pkg::word_t op_b;
  logic [4:0]    shamt;
  logic          cond;

  always_comb begin
    case (ctrl.src_a)
      rv_pkg::SRC_A_RS1: op_a = rs1_data;
      rv_pkg::SRC_A_PC:  op_a = pc;
      default:           op_a = '0;
    endcase
    op_b = (ctrl.src_b == rv_pkg::SRC_B_IMM) ? ctrl.imm : rs2_data;
  end

  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      rv_pkg::ALU_ADD:    alu_result = op_a + op_b;
      rv_pkg::ALU_SUB:    alu_result = op_a - op_b;
      rv_pkg::ALU_SLL:    alu_result = op_a << shamt;
      rv_pkg::ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_pkg::ALU_SLTU:   alu_result = {31'b0, op_a < op_b};
      rv_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
      rv_pkg::ALU_SRL:    alu_result = op_a >> shamt;
      rv_pkg::ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt);
      rv_pkg::ALU_OR:     alu_result = op_a | op_b;
      rv_pkg::ALU_AND:    alu_result = op_a & op_b;
      rv_pkg::ALU_PASS_B: alu_result = op_b;
      default:            alu_result = op_a + op_b;
    endcase
  end

  // Branches always compare the two registers, whatever the ALU operands are
  always_comb begin
    case (ctrl.branch)
      rv_pkg::BR_EQ:  cond = (rs1_data == rs2_data);
      rv_pkg::BR_NE:  cond = (rs1_data != rs2_data);
      rv_pkg::BR_LT:  cond = ($signed(rs1_data) < $signed(rs2_data));
      rv_pkg::BR_GE:  cond = ($signed(rs1_data) >= $signed(rs2_data));
      rv_pkg::BR_LTU: cond = (rs1_data < rs2_data);
      rv_pkg::BR_GEU: cond = (rs1_data >= rs2_data);
      default:        cond = 1'b0;
    endcase
  end

  assign taken  = cond | ctrl.jal | ctrl.jalr;
  assign target = ctrl.jalr ? ((rs1_data + ctrl.imm) & ~32'd1) : (pc + ctrl.imm);

endmodule

//--- hw/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch (
  input  logic          clk,
  input  logic          reset,
  input  logic          taken,
  input  rv_pkg::word_t target,
  output rv_pkg::word_t instr_addr,
  input  rv_pkg::word_t instr_in,
  output rv_pkg::word_t instr,
  output rv_pkg::word_t pc,
  output logic          valid
);

  rv_pkg::word_t fetch_pc;

  // A taken transfer redirects the PC and drops the word fetched alongside it
  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_pc <= rv_pkg::RESET_PC;
      valid    <= 1'b0;
    end else begin
      if (taken) begin
        fetch_pc <= target;
      end else begin
        fetch_pc <= fetch_pc + 32'd4;
      end
      valid <= ~taken;
    end
  end

  always_ff @(posedge clk) begin
    instr <= instr_in;
    pc    <= fetch_pc;
  end

  assign instr_addr = fetch_pc;

  // JALR only clears bit 0, so a bad target would show up here
  a_fetch_aligned: assert property (@(posedge clk) disable iff (reset)
    instr_addr[1:0] == 2'b00)
    else $error("rv_fetch: misaligned fetch address %h", instr_addr);

endmodule

//--- hw/rv_lsu.sv
`timescale 1ns/1ps

module rv_lsu (
  input  rv_pkg::ctrl_t    ctrl,
  input  rv_pkg::word_t    alu_result,
  input  rv_pkg::word_t    rs2_data,
  input  rv_pkg::word_t    pc,
  input  rv_pkg::word_t    data_in,
  output rv_pkg::word_t    data_addr,
  output rv_pkg::byte_en_t data_wr,
  output logic [7:0]       data_out0,
  output logic [7:0]       data_out1,
  output logic [7:0]       data_out2,
  output logic [7:0]       data_out3,
  output rv_pkg::word_t    wb_data
);

  logic [1:0]       offset;
  rv_pkg::byte_en_t size_mask;
  rv_pkg::word_t    store_data;
  rv_pkg::word_t    load_word;
  rv_pkg::word_t    load_val;

  assign data_addr = {alu_result[31:2], 2'b00};
  assign offset    = alu_result[1:0];

  // Replicating the data means the mask alone picks the lanes
  always_comb begin
    case (ctrl.mem_size)
      rv_pkg::SIZE_BYTE: begin
        size_mask  = 4'b0001;
        store_data = {4{rs2_data[7:0]}};
      end
      rv_pkg::SIZE_HALF: begin
        size_mask  = 4'b0011;
        store_data = {2{rs2_data[15:0]}};
      end
      default: begin
        size_mask  = 4'b1111;
        store_data = rs2_data;
      end
    endcase
  end

  assign data_wr   = ctrl.mem_wr ? rv_pkg::byte_en_t'(size_mask << offset) : '0;
  assign data_out0 = store_data[7:0];
  assign data_out1 = store_data[15:8];
  assign data_out2 = store_data[23:16];
  assign data_out3 = store_data[31:24];

  assign load_word = ctrl.mem_rd ? (data_in >> {offset, 3'b000}) : '0;

  always_comb begin
    case (ctrl.mem_size)
      rv_pkg::SIZE_BYTE: load_val = {{24{load_word[7] & ~ctrl.load_unsigned}}, load_word[7:0]};
      rv_pkg::SIZE_HALF: load_val = {{16{load_word[15] & ~ctrl.load_unsigned}}, load_word[15:0]};
      default:           load_val = load_word;
    endcase
  end

  always_comb begin
    case (ctrl.wb_sel)
      rv_pkg::WB_LOAD: wb_data = load_val;
      rv_pkg::WB_LINK: wb_data = pc + 32'd4;
      default:         wb_data = alu_result;
    endcase
  end

  // Half and word stores must be naturally aligned
  always_comb begin
    if (ctrl.mem_wr && ctrl.mem_size == rv_pkg::SIZE_HALF) begin
      a_half_mask: assert final (data_wr == 4'b0011 || data_wr == 4'b1100)
        else $error("rv_lsu: half store mask %b", data_wr);
    end
    if (ctrl.mem_wr && ctrl.mem_size == rv_pkg::SIZE_WORD) begin
      a_word_mask: assert final (data_wr == 4'b1111)
        else $error("rv_lsu: word store mask %b", data_wr);
    end
  end

endmodule

//--- hw/rv_pkg.sv
package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  byte_en_t;
  typedef logic [3:0]  alu_op_t;

  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  localparam alu_op_t ALU_PASS_B = 4'd10;

  localparam logic [1:0] SRC_A_RS1  = 2'd0;
  localparam logic [1:0] SRC_A_PC   = 2'd1;
  localparam logic [1:0] SRC_A_ZERO = 2'd2;
  localparam logic [1:0] SRC_B_RS2  = 2'd0;
  localparam logic [1:0] SRC_B_IMM  = 2'd1;

  localparam logic [1:0] WB_ALU  = 2'd0;
  localparam logic [1:0] WB_LOAD = 2'd1;
  localparam logic [1:0] WB_LINK = 2'd2;

  // Size codes equal funct3[1:0] of the load and store encodings
  localparam logic [1:0] SIZE_BYTE = 2'd0;
  localparam logic [1:0] SIZE_HALF = 2'd1;
  localparam logic [1:0] SIZE_WORD = 2'd2;

  localparam logic [2:0] BR_NONE = 3'd0;
  localparam logic [2:0] BR_EQ   = 3'd1;
  localparam logic [2:0] BR_NE   = 3'd2;
  localparam logic [2:0] BR_LT   = 3'd3;
  localparam logic [2:0] BR_GE   = 3'd4;
  localparam logic [2:0] BR_LTU  = 3'd5;
  localparam logic [2:0] BR_GEU  = 3'd6;

  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_JAL    = 7'h6f;
  localparam logic [6:0] OPC_JALR   = 7'h67;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_OPIMM  = 7'h13;
  localparam logic [6:0] OPC_OP     = 7'h33;

  localparam word_t RESET_PC = 32'h0000_0000;

  // All-zero value is the inactive control word
  typedef struct packed {
    logic       reg_wr;
    logic [1:0] wb_sel;
    logic       mem_rd;
    logic       mem_wr;
    logic [1:0] mem_size;
    logic       load_unsigned;
    logic [1:0] src_a;
    logic [1:0] src_b;
    alu_op_t    alu_op;
    logic [2:0] branch;
    logic       jal;
    logic       jalr;
    word_t      imm;
  } ctrl_t;

endpackage

//--- hw/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic              clk,
  input  logic              reset,
  input  logic              wr,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  input  rv_pkg::reg_addr_t rd_addr,
  input  rv_pkg::word_t     wd,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);

  // No storage behind x0
  rv_pkg::word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr && rd_addr != '0) begin
      regs[rd_addr] <= wd;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  a_x0_zero: assert property (@(posedge clk) disable iff (reset)
    ((rs1_addr == '0) |-> (rs1_data == '0)) and ((rs2_addr == '0) |-> (rs2_data == '0)))
    else $error("rv_regfile: x0 read back nonzero");

endmodule
